//--- compile.f
+incdir+rtl
+incdir+tests
rtl/ex_pkg.sv
rtl/ex_if.sv
rtl/operand_select.sv
rtl/mult_unit.sv
rtl/alu_unit.sv
rtl/branch_cond.sv
rtl/result_merge.sv
rtl/ex_stage.sv
tests/tb_ex_stage.sv

//--- rtl/alu_unit.sv
// single cycle alu with multiplier sequencing
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu_unit import ex_pkg::*; (
	input logic clock,
	input logic reset,
	alu_op_if.sink op,
	alu_res_if.source res
);

	alu_state_t state, next_state;
	logic is_mult;
	logic start, mult_done;
	logic hi_next, hi_sel; // return upper product half
	mult_sign_t sign;
	logic [2*`EX_XLEN-1:0] product;
	logic [`EX_XLEN-1:0] alu_result, mult_result;

	assign is_mult = op.func inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};

	mult_unit u_mult (
		.clock(clock),
		.reset(reset),
		.start(start),
		.sign(sign),
		.mcand(op.opa),
		.mplier(op.opb),
		.product(product),
		.done(mult_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// function decode and integer ops
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		alu_result = `EX_ALU_BAD; // also left here for multiplies
		sign = SIGN_NONE;
		hi_next = 1'b0;
		case (op.func)
			ALU_ADD:    alu_result = op.opa + op.opb;
			ALU_SUB:    alu_result = op.opa - op.opb;
			ALU_SLT:    alu_result = {{(`EX_XLEN-1){1'b0}}, $signed(op.opa) < $signed(op.opb)};
			ALU_SLTU:   alu_result = {{(`EX_XLEN-1){1'b0}}, op.opa < op.opb};
			ALU_AND:    alu_result = op.opa & op.opb;
			ALU_OR:     alu_result = op.opa | op.opb;
			ALU_XOR:    alu_result = op.opa ^ op.opb;
			ALU_SLL:    alu_result = op.opa << op.opb[4:0]; // shamt is low 5 bits
			ALU_SRL:    alu_result = op.opa >> op.opb[4:0];
			ALU_SRA:    alu_result = $signed(op.opa) >>> op.opb[4:0];
			ALU_MUL:    sign = SIGN_BOTH; // low half same for any sign
			ALU_MULH: begin
				sign = SIGN_BOTH;
				hi_next = 1'b1;
			end
			ALU_MULHSU: begin
				sign = SIGN_A; // rs1 signed, rs2 unsigned
				hi_next = 1'b1;
			end
			ALU_MULHU:  hi_next = 1'b1;
			default:    alu_result = `EX_ALU_BAD;
		endcase
	end

	assign mult_result = hi_sel ? product[2*`EX_XLEN-1:`EX_XLEN] : product[`EX_XLEN-1:0];

	////////////////////////////////////////////////////////////////////////////
	// sequencing fsm
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		start = 1'b0;
		res.accept_mult = 1'b0;
		res.done = 1'b0;
		res.busy = 1'b0;
		case (state)
			IDLE: begin
				if (op.valid & is_mult) begin
					start = 1'b1; // multiplier loads this edge
					res.accept_mult = 1'b1;
					next_state = MULT_WAIT;
				end else if (op.valid) begin
					res.done = 1'b1; // same cycle result
				end
			end
			MULT_WAIT: begin
				res.busy = 1'b1; // upstream holds off
				if (mult_done) begin
					res.done = 1'b1;
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// result source follows the state, func is stale during a multiply
	assign res.result = (state == MULT_WAIT) ? mult_result : alu_result;

	always_ff @(posedge clock) begin
		if (reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clock) begin
		if (start)
			hi_sel <= hi_next; // held until the product returns
	end

	// upstream must respect busy
	a_no_issue_busy: assert property (@(posedge clock) disable iff (reset)
		op.valid |-> !res.busy)
		else $error("instruction issued while busy");

	// product returns after the fixed latency and not before
	a_mult_latency: assert property (@(posedge clock) disable iff (reset)
		res.accept_mult |=> (!res.done)[*(`EX_MULT_CYCLES-1)] ##1 res.done)
		else $error("multiply latency broken");

endmodule

//--- rtl/branch_cond.sv
// branch condition compare
`timescale 1ns/1ps
`include "ex_defines.svh"

module branch_cond import ex_pkg::*; (
	input logic [`EX_XLEN-1:0] rs1,
	input logic [`EX_XLEN-1:0] rs2,
	input br_func_t funct3,
	output logic cond
);

	logic eq, lt_s, lt_u;

	// shared comparators
	assign eq = (rs1 == rs2);
	assign lt_s = ($signed(rs1) < $signed(rs2));
	assign lt_u = (rs1 < rs2);

	always_comb begin
		cond = 1'b0; // reserved funct3 never taken
		case (funct3)
			BR_BEQ:  cond = eq;
			BR_BNE:  cond = !eq;
			BR_BLT:  cond = lt_s;
			BR_BGE:  cond = !lt_s;
			BR_BLTU: cond = lt_u;
			BR_BGEU: cond = !lt_u;
			default: cond = 1'b0;
		endcase
	end

endmodule

//--- rtl/ex_defines.svh
// execute stage widths and latencies
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// datapath sizes
////////////////////////////////////////////////////////////////////////////

`define EX_XLEN 32 // integer register width
`define EX_TAG_W 6 // destination register tag

////////////////////////////////////////////////////////////////////////////
// multiplier timing
////////////////////////////////////////////////////////////////////////////

// start to done distance in clocks
`define EX_MULT_CYCLES 4

// multiplier bits retired per clock
`define EX_MULT_SLICE (`EX_XLEN / `EX_MULT_CYCLES)

////////////////////////////////////////////////////////////////////////////
// marker values for impossible selects
////////////////////////////////////////////////////////////////////////////

`define EX_OPA_BAD 32'hdead_0a0a // bad opa select
`define EX_OPB_BAD 32'hdead_0b0b // bad opb select
`define EX_ALU_BAD 32'hbad0_a1a1 // unknown alu func

`endif

//--- rtl/ex_if.sv
// operand and result bundles
`timescale 1ns/1ps
`include "ex_defines.svh"

// selected operands heading into the alu
interface alu_op_if import ex_pkg::*; ();
	logic valid; // one strobe per instruction
	logic [`EX_XLEN-1:0] opa;
	logic [`EX_XLEN-1:0] opb;
	alu_func_t func;

	modport source (output valid, opa, opb, func);
	modport sink (input valid, opa, opb, func);
endinterface

// alu outcome heading into the output register
interface alu_res_if ();
	logic done; // result ready this cycle
	logic [`EX_XLEN-1:0] result;
	logic accept_mult; // multiply taken this cycle
	logic busy; // multiply in flight

	modport source (output done, result, accept_mult, busy);
	modport sink (input done, result, accept_mult, busy);
endinterface

//--- rtl/ex_pkg.sv
// execute stage types
package ex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// alu function codes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_SLT    = 4'h2,
		ALU_SLTU   = 4'h3,
		ALU_AND    = 4'h4,
		ALU_OR     = 4'h5,
		ALU_XOR    = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha, // low half
		ALU_MULH   = 4'hb, // high half, signed x signed
		ALU_MULHSU = 4'hc, // high half, signed x unsigned
		ALU_MULHU  = 4'hd  // high half, unsigned x unsigned
	} alu_func_t;

	////////////////////////////////////////////////////////////////////////////
	// operand selects
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_NPC  = 2'h1,
		OPA_IS_PC   = 2'h2,
		OPA_IS_ZERO = 2'h3
	} opa_sel_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} opb_sel_t;

	// branch compare, encoded as funct3
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} br_func_t;

	typedef enum logic {IDLE, MULT_WAIT} alu_state_t;

	// which multiplier operands are signed
	typedef enum logic [1:0] {
		SIGN_NONE = 2'b00,
		SIGN_A    = 2'b01, // mcand only
		SIGN_BOTH = 2'b11
	} mult_sign_t;

endpackage

//--- rtl/ex_stage.sv
// rv32 execute stage
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage import ex_pkg::*; (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input logic [`EX_XLEN-1:0] in_pc,
	input logic [`EX_XLEN-1:0] in_npc,
	input logic [`EX_XLEN-1:0] in_inst,
	input logic [`EX_XLEN-1:0] in_rs1_value,
	input logic [`EX_XLEN-1:0] in_rs2_value,
	input opa_sel_t in_opa_select,
	input opb_sel_t in_opb_select,
	input alu_func_t in_alu_func,
	input logic in_cond_branch,
	input logic in_uncond_branch,
	input logic [`EX_TAG_W-1:0] in_dest_tag,
	output logic out_valid,
	output logic [`EX_XLEN-1:0] out_result,
	output logic out_take_branch,
	output logic [`EX_TAG_W-1:0] out_dest_tag,
	output logic busy
);

	logic cond; // branch compare result

	alu_op_if op_bus ();
	alu_res_if res_bus ();

	////////////////////////////////////////////////////////////////////////////
	// operands, alu and compare
	////////////////////////////////////////////////////////////////////////////

	operand_select u_opsel (
		.in_valid(in_valid),
		.in_pc(in_pc),
		.in_npc(in_npc),
		.in_rs1_value(in_rs1_value),
		.in_rs2_value(in_rs2_value),
		.in_inst(in_inst),
		.in_opa_select(in_opa_select),
		.in_opb_select(in_opb_select),
		.in_alu_func(in_alu_func),
		.op(op_bus.source)
	);

	alu_unit u_alu (.clock(clock), .reset(reset), .op(op_bus.sink), .res(res_bus.source));

	branch_cond u_br (
		.rs1(in_rs1_value),
		.rs2(in_rs2_value),
		.funct3(br_func_t'(in_inst[14:12])), // b-type funct3
		.cond(cond)
	);

	result_merge u_merge (
		.clock(clock),
		.reset(reset),
		.res(res_bus.sink),
		.cond(cond),
		.in_cond_branch(in_cond_branch),
		.in_uncond_branch(in_uncond_branch),
		.in_dest_tag(in_dest_tag),
		.out_valid(out_valid),
		.out_result(out_result),
		.out_take_branch(out_take_branch),
		.out_dest_tag(out_dest_tag)
	);

	assign busy = res_bus.busy; // stall request upstream

endmodule

//--- rtl/mult_unit.sv
// sequential shift-add multiplier
`timescale 1ns/1ps
`include "ex_defines.svh"

module mult_unit import ex_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	input mult_sign_t sign,
	input logic [`EX_XLEN-1:0] mcand,
	input logic [`EX_XLEN-1:0] mplier,
	output logic [2*`EX_XLEN-1:0] product,
	output logic done
);

	localparam int CNT_W = $clog2(`EX_MULT_CYCLES) + 1;

	logic mcand_signed, mplier_signed;
	logic [2*`EX_XLEN-1:0] mcand_ext; // extended multiplicand
	logic [2*`EX_XLEN-1:0] corr; // fixup for a negative multiplier
	logic [2*`EX_XLEN-1:0] mcand_r, acc;
	logic [`EX_XLEN-1:0] mplier_r; // bits not yet consumed
	logic [CNT_W-1:0] cnt; // slices left

	// one slice worth of partial products
	function automatic logic [2*`EX_XLEN-1:0] slice_pp(
		input logic [2*`EX_XLEN-1:0] a,
		input logic [`EX_MULT_SLICE-1:0] s
	);
		logic [2*`EX_XLEN-1:0] sum;
		sum = '0;
		for (int i = 0; i < `EX_MULT_SLICE; i++) begin
			if (s[i])
				sum = sum + (a << i);
		end
		return sum;
	endfunction

	assign mcand_signed = (sign != SIGN_NONE);
	assign mplier_signed = (sign == SIGN_BOTH);
	assign mcand_ext = {{`EX_XLEN{mcand_signed & mcand[`EX_XLEN-1]}}, mcand};

	// multiplier bits are summed as unsigned, so a negative one owes mcand << xlen
	assign corr = (mplier_signed & mplier[`EX_XLEN-1]) ? -(mcand_ext << `EX_XLEN) : '0;

	// count and done strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				cnt <= CNT_W'(`EX_MULT_CYCLES - 1); // first slice goes in now
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
				done <= (cnt == CNT_W'(1)); // last slice lands
			end
		end
	end

	// accumulator and shifting operands
	always_ff @(posedge clock) begin
		if (start) begin
			acc <= corr + slice_pp(mcand_ext, mplier[`EX_MULT_SLICE-1:0]);
			mcand_r <= mcand_ext << `EX_MULT_SLICE;
			mplier_r <= mplier >> `EX_MULT_SLICE;
		end else if (cnt != '0) begin
			acc <= acc + slice_pp(mcand_r, mplier_r[`EX_MULT_SLICE-1:0]);
			mcand_r <= mcand_r << `EX_MULT_SLICE;
			mplier_r <= mplier_r >> `EX_MULT_SLICE;
		end
	end

	assign product = acc;

	// the alu fsm must never restart us mid product
	a_no_restart: assert property (@(posedge clock) disable iff (reset)
		start |-> (cnt == '0))
		else $error("multiplier started while counting");

endmodule

//--- rtl/operand_select.sv
// alu operand muxes
`timescale 1ns/1ps
`include "ex_defines.svh"

module operand_select import ex_pkg::*; (
	input logic in_valid,
	input logic [`EX_XLEN-1:0] in_pc,
	input logic [`EX_XLEN-1:0] in_npc,
	input logic [`EX_XLEN-1:0] in_rs1_value,
	input logic [`EX_XLEN-1:0] in_rs2_value,
	input logic [`EX_XLEN-1:0] in_inst,
	input opa_sel_t in_opa_select,
	input opb_sel_t in_opb_select,
	input alu_func_t in_alu_func,
	alu_op_if.source op
);

	logic [`EX_XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;

	////////////////////////////////////////////////////////////////////////////
	// rv32 immediates, all sign extended from bit 31
	////////////////////////////////////////////////////////////////////////////

	assign i_imm = {{(`EX_XLEN-12){in_inst[31]}}, in_inst[31:20]};
	assign s_imm = {{(`EX_XLEN-12){in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
	assign b_imm = {{(`EX_XLEN-13){in_inst[31]}}, in_inst[31], in_inst[7],
		in_inst[30:25], in_inst[11:8], 1'b0}; // halfword aligned
	assign u_imm = {in_inst[31:12], 12'b0}; // upper 20 bits
	assign j_imm = {{(`EX_XLEN-21){in_inst[31]}}, in_inst[31], in_inst[19:12],
		in_inst[20], in_inst[30:21], 1'b0};

	// operand a
	always_comb begin
		op.opa = `EX_OPA_BAD; // shows up only on a bad select
		case (in_opa_select)
			OPA_IS_RS1:  op.opa = in_rs1_value;
			OPA_IS_NPC:  op.opa = in_npc; // link address for jal/jalr
			OPA_IS_PC:   op.opa = in_pc; // auipc and branch target
			OPA_IS_ZERO: op.opa = '0; // lui
			default:     op.opa = `EX_OPA_BAD;
		endcase
	end

	// operand b
	always_comb begin
		op.opb = `EX_OPB_BAD;
		case (in_opb_select)
			OPB_IS_RS2:   op.opb = in_rs2_value;
			OPB_IS_I_IMM: op.opb = i_imm;
			OPB_IS_S_IMM: op.opb = s_imm;
			OPB_IS_B_IMM: op.opb = b_imm;
			OPB_IS_U_IMM: op.opb = u_imm;
			OPB_IS_J_IMM: op.opb = j_imm;
			default:      op.opb = `EX_OPB_BAD;
		endcase
	end

	assign op.valid = in_valid;
	assign op.func = in_alu_func;

endmodule

//--- rtl/result_merge.sv
// execute output register
`timescale 1ns/1ps
`include "ex_defines.svh"

module result_merge (
	input logic clock,
	input logic reset,
	alu_res_if.sink res,
	input logic cond,
	input logic in_cond_branch,
	input logic in_uncond_branch,
	input logic [`EX_TAG_W-1:0] in_dest_tag,
	output logic out_valid,
	output logic [`EX_XLEN-1:0] out_result,
	output logic out_take_branch,
	output logic [`EX_TAG_W-1:0] out_dest_tag
);

	logic take_now; // live take branch
	logic held_take;
	logic [`EX_TAG_W-1:0] held_tag; // multiply side band

	// jumps always, branches when the compare holds
	assign take_now = in_uncond_branch | (in_cond_branch & cond);

	////////////////////////////////////////////////////////////////////////////
	// side band capture for a multiply in flight
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (res.accept_mult) begin
			held_tag <= in_dest_tag; // inputs move on next cycle
			held_take <= take_now;
		end
	end

	// strobe
	always_ff @(posedge clock) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= res.done;
	end

	// payload, busy means the result is a product
	always_ff @(posedge clock) begin
		if (res.done) begin
			out_result <= res.result;
			out_take_branch <= res.busy ? held_take : take_now;
			out_dest_tag <= res.busy ? held_tag : in_dest_tag;
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f compile.f \
	--top-module tb_ex_stage --Mdir obj_dir \
	&& ./obj_dir/Vtb_ex_stage | tee /dev/stderr | grep -qx '>>> PASS' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tests/ex_ref_model.svh
// execute stage reference model
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// operands and immediates
////////////////////////////////////////////////////////////////////////////

// rv32 immediate formats
function automatic logic [`EX_XLEN-1:0] imm_value(input opb_sel_t sel,
	input logic [`EX_XLEN-1:0] inst);
	logic signed [11:0] i12; // i and s formats
	logic signed [12:0] b13;
	logic signed [20:0] j21;
	case (sel)
		OPB_IS_I_IMM: begin
			i12 = inst[31:20];
			return 32'(i12);
		end
		OPB_IS_S_IMM: begin
			i12 = {inst[31:25], inst[11:7]};
			return 32'(i12);
		end
		OPB_IS_B_IMM: begin
			b13 = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			return 32'(b13);
		end
		OPB_IS_U_IMM: return {inst[31:12], 12'h000};
		OPB_IS_J_IMM: begin
			j21 = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			return 32'(j21);
		end
		default: return '0;
	endcase
endfunction

function automatic logic [`EX_XLEN-1:0] first_operand(input opa_sel_t sel,
	input logic [`EX_XLEN-1:0] pc, npc, rs1);
	case (sel)
		OPA_IS_RS1: return rs1;
		OPA_IS_NPC: return npc;
		OPA_IS_PC:  return pc;
		default:    return '0; // zero source
	endcase
endfunction

function automatic logic [`EX_XLEN-1:0] second_operand(input opb_sel_t sel,
	input logic [`EX_XLEN-1:0] inst, rs2);
	return (sel == OPB_IS_RS2) ? rs2 : imm_value(sel, inst);
endfunction

////////////////////////////////////////////////////////////////////////////
// alu, multiply and branch rules
////////////////////////////////////////////////////////////////////////////

function automatic logic [`EX_XLEN-1:0] compute_alu(input alu_func_t func,
	input logic [`EX_XLEN-1:0] a, b);
	longint sa, sb, ua, ub; // 64 bit views of the operands
	logic [63:0] p;
	sa = longint'($signed(a));
	sb = longint'($signed(b));
	ua = longint'({32'h0, a});
	ub = longint'({32'h0, b});
	case (func)
		ALU_ADD:    return a + b;
		ALU_SUB:    return a - b;
		ALU_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		ALU_SLTU:   return (a < b) ? 32'd1 : 32'd0;
		ALU_AND:    return a & b;
		ALU_OR:     return a | b;
		ALU_XOR:    return a ^ b;
		ALU_SLL:    return a << b[4:0];
		ALU_SRL:    return a >> b[4:0];
		ALU_SRA:    return 32'($signed(a) >>> b[4:0]);
		ALU_MUL: begin
			p = 64'(sa * sb);
			return p[31:0];
		end
		ALU_MULH: begin
			p = 64'(sa * sb);
			return p[63:32];
		end
		ALU_MULHSU: begin
			p = 64'(sa * ub);
			return p[63:32];
		end
		ALU_MULHU: begin
			p = 64'(ua * ub);
			return p[63:32];
		end
		default: return '0;
	endcase
endfunction

// reserved funct3 never branches
function automatic logic branch_taken(input logic [2:0] f3, input logic [`EX_XLEN-1:0] a, b);
	case (f3)
		3'b000:  return a == b;
		3'b001:  return a != b;
		3'b100:  return $signed(a) < $signed(b);
		3'b101:  return $signed(a) >= $signed(b);
		3'b110:  return a < b;
		3'b111:  return a >= b;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

//--- tests/tb_ex_stage.sv
// execute stage testbench
`timescale 1ns/1ps
`include "ex_defines.svh"

module tb_ex_stage import ex_pkg::*; ();

	`include "ex_ref_model.svh"

	// instruction counts per section, these set the timeout
	localparam int RAND_ALU = 6;
	localparam int RAND_MUL = 4;
	localparam int SIDE_ROUNDS = 8;
	localparam int N_INSTR = 10 * (9 + RAND_ALU) + 4 * (9 + RAND_MUL) + 4 * 6 + 8 * 5 * 3
		+ SIDE_ROUNDS * 3;
	localparam int TIMEOUT_CYCLES = N_INSTR * (`EX_MULT_CYCLES + 2) + 20;

	localparam logic [31:0] EDGE_VALS [3] = '{32'h0, 32'hffff_ffff, 32'h8000_0000};
	// equal, less, greater, then signed and unsigned orders disagree
	localparam logic [31:0] BR_A [5] = '{32'h1234_5678, 32'd1, 32'd2, 32'hffff_ffff, 32'd1};
	localparam logic [31:0] BR_B [5] = '{32'h1234_5678, 32'd2, 32'd1, 32'd1, 32'hffff_ffff};

	typedef struct packed {
		logic [`EX_XLEN-1:0] result;
		logic take;
		logic [`EX_TAG_W-1:0] tag;
		logic [31:0] issue_cycle;
		logic is_mult; // sets the expected latency
	} expect_t;

	logic clock, reset, in_valid;
	logic [`EX_XLEN-1:0] in_pc, in_npc, in_inst, in_rs1_value, in_rs2_value;
	opa_sel_t in_opa_select;
	opb_sel_t in_opb_select;
	alu_func_t in_alu_func;
	logic in_cond_branch, in_uncond_branch;
	logic [`EX_TAG_W-1:0] in_dest_tag;
	logic out_valid, out_take_branch, busy;
	logic [`EX_XLEN-1:0] out_result;
	logic [`EX_TAG_W-1:0] out_dest_tag;

	expect_t exp_q [$]; // scoreboard, issue order
	logic [31:0] rng_state = 32'h5cb41896;
	int cycle = 0;
	int busy_run = 0;
	int result_errors = 0, take_errors = 0, tag_errors = 0, timing_errors = 0;

	ex_stage DUT (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	function automatic logic [31:0] rand32();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_result(input logic [`EX_XLEN-1:0] got, exp);
		if (got !== exp) begin
			$display("FAIL out_result: got %h expected %h", got, exp);
			result_errors++;
		end
	endtask

	task automatic verify_take(input logic got, exp);
		if (got !== exp) begin
			$display("FAIL out_take_branch: got %h expected %h", got, exp);
			take_errors++;
		end
	endtask

	task automatic compare_tag(input logic [`EX_TAG_W-1:0] got, exp);
		if (got !== exp) begin
			$display("FAIL out_dest_tag: got %h expected %h", got, exp);
			tag_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// junk on the side band while a multiply is in flight
	task automatic scramble_inputs();
		logic [31:0] r;
		r = rand32();
		in_inst = rand32();
		in_rs1_value = rand32();
		in_rs2_value = rand32();
		in_cond_branch = r[0];
		in_uncond_branch = r[1];
		in_dest_tag = r[`EX_TAG_W+1:2];
	endtask

	// called 1 ns after a rising edge, returns at the same point
	task automatic drive_instr(input alu_func_t func, input opa_sel_t asel,
		input opb_sel_t bsel, input logic [31:0] pc, inst, rs1, rs2,
		input logic cbr, ubr, input logic [`EX_TAG_W-1:0] tag);
		expect_t e;
		logic [31:0] a, b;
		while (busy) begin
			in_valid = 1'b0;
			scramble_inputs();
			@(posedge clock);
			#1;
		end
		a = first_operand(asel, pc, pc + 32'd4, rs1);
		b = second_operand(bsel, inst, rs2);
		e.result = compute_alu(func, a, b);
		e.take = ubr | (cbr & branch_taken(inst[14:12], rs1, rs2));
		e.tag = tag;
		e.issue_cycle = cycle;
		e.is_mult = func inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
		exp_q.push_back(e);
		in_pc = pc;
		in_npc = pc + 32'd4;
		in_inst = inst;
		in_rs1_value = rs1;
		in_rs2_value = rs2;
		in_opa_select = asel;
		in_opb_select = bsel;
		in_alu_func = func;
		in_cond_branch = cbr;
		in_uncond_branch = ubr;
		in_dest_tag = tag;
		in_valid = 1'b1; // one cycle strobe
		@(posedge clock);
		#1;
		in_valid = 1'b0;
	endtask

	// register-register op with random side band
	task automatic issue_rr(input alu_func_t func, input logic [31:0] a, b);
		logic [31:0] r;
		r = rand32();
		drive_instr(func, OPA_IS_RS1, OPB_IS_RS2, rand32() & 32'hffff_fffc, rand32(), a, b,
			r[0], r[1], r[`EX_TAG_W+1:2]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// output checking
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin : compare_outputs
		expect_t e;
		int lat, want;
		if (!reset && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("out_valid rose with nothing outstanding at cycle %0d", cycle);
				timing_errors++;
			end else begin
				e = exp_q.pop_front();
				check_result(out_result, e.result);
				verify_take(out_take_branch, e.take);
				compare_tag(out_dest_tag, e.tag);
				lat = cycle - int'(e.issue_cycle);
				want = e.is_mult ? `EX_MULT_CYCLES + 1 : 1;
				if (lat != want) begin
					$display("out_valid came %0d cycles after issue, wanted %0d", lat, want);
					timing_errors++;
				end
			end
		end
	end

	// busy level length per multiply
	always @(negedge clock) begin
		if (reset)
			busy_run = 0;
		else if (busy)
			busy_run++;
		else if (busy_run != 0) begin
			if (busy_run != `EX_MULT_CYCLES) begin
				$display("busy stayed high %0d cycles, wanted %0d", busy_run, `EX_MULT_CYCLES);
				timing_errors++;
			end
			busy_run = 0;
		end
	end

	initial begin
		wait (cycle >= TIMEOUT_CYCLES);
		$display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] r, inst;
		reset = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_npc = 32'd4;
		in_inst = '0;
		in_rs1_value = '0;
		in_rs2_value = '0;
		in_opa_select = OPA_IS_RS1;
		in_opb_select = OPB_IS_RS2;
		in_alu_func = ALU_ADD;
		in_cond_branch = 1'b0;
		in_uncond_branch = 1'b0;
		in_dest_tag = '0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		if (out_valid !== 1'b0 || busy !== 1'b0) begin
			$display("out_valid or busy not low right after reset");
			timing_errors++;
		end
		repeat (3) @(posedge clock); // idle, nothing may come out
		#1;

		// integer ops, edge pairs then random
		for (int f = 0; f < 10; f++) begin
			for (int i = 0; i < 3; i++)
				for (int j = 0; j < 3; j++)
					issue_rr(alu_func_t'(4'(f)), EDGE_VALS[i], EDGE_VALS[j]);
			for (int k = 0; k < RAND_ALU; k++)
				issue_rr(alu_func_t'(4'(f)), rand32(), rand32());
		end

		// multiplies, all sign mixes come from edges and random
		for (int f = 10; f < 14; f++) begin
			for (int i = 0; i < 3; i++)
				for (int j = 0; j < 3; j++)
					issue_rr(alu_func_t'(4'(f)), EDGE_VALS[i], EDGE_VALS[j]);
			for (int k = 0; k < RAND_MUL; k++)
				issue_rr(alu_func_t'(4'(f)), rand32(), rand32());
		end

		// every operand select through add
		for (int a = 0; a < 4; a++)
			for (int b = 0; b < 6; b++) begin
				r = rand32();
				drive_instr(ALU_ADD, opa_sel_t'(2'(a)), opb_sel_t'(3'(b)),
					rand32() & 32'hffff_fffc, rand32(), rand32(), rand32(),
					1'b0, 1'b0, r[`EX_TAG_W-1:0]);
			end

		// branches: funct3 x operand pair x cond/uncond/none
		for (int f3 = 0; f3 < 8; f3++)
			for (int p = 0; p < 5; p++)
				for (int kind = 0; kind < 3; kind++) begin
					r = rand32();
					inst = rand32();
					inst = {inst[31:15], 3'(f3), inst[11:0]};
					drive_instr(ALU_ADD, OPA_IS_PC, OPB_IS_B_IMM, r & 32'hffff_fffc, inst,
						BR_A[p], BR_B[p], kind == 0, kind == 1, r[`EX_TAG_W+1:2]);
				end

		// multiply then back to back followers
		for (int k = 0; k < SIDE_ROUNDS; k++) begin
			r = rand32();
			drive_instr(alu_func_t'(4'(10 + k % 4)), OPA_IS_RS1, OPB_IS_RS2,
				rand32() & 32'hffff_fffc, rand32(), rand32(), rand32(),
				r[0], r[1], r[`EX_TAG_W+1:2]);
			issue_rr(alu_func_t'(4'(r[11:8] % 4'd10)), rand32(), rand32());
			issue_rr(alu_func_t'(4'(r[15:12] % 4'd10)), rand32(), rand32());
		end

		while (exp_q.size() != 0)
			@(posedge clock);
		repeat (4) @(posedge clock); // catch stray strobes

		$display("errors: result %0d, take_branch %0d, dest_tag %0d, timing %0d",
			result_errors, take_errors, tag_errors, timing_errors);
		if (result_errors + take_errors + tag_errors + timing_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
